/* common/vtb_settings.svh */
// Depth must stay a power of two from the address width and the midpoint is always half of it
`ifndef VTB_SETTINGS_SVH
`define VTB_SETTINGS_SVH

// Pixel format
`define VTB_PPC 2 // Pixels per clock
`define VTB_BPC 8 // Bits per component

// FIFO geometry
`define VTB_FIFO_ADR 10 // Address width

// Derived sizes
`define VTB_FIFO_WRDS (1 << `VTB_FIFO_ADR) // Words in buffer
`define VTB_FIFO_MID (`VTB_FIFO_WRDS / 2) // Lock threshold

`endif

/* common/vtb_pkg.sv */
// Types follow the pixel and FIFO sizes of the settings header and pack each pixel b, r, g from the top
`include "vtb_settings.svh"

package vtb_pkg;

	// One pixel, blue in the top bits
	typedef struct packed {
		logic [`VTB_BPC-1:0] b;
		logic [`VTB_BPC-1:0] r;
		logic [`VTB_BPC-1:0] g;
	} vtb_pix_t;

	// FIFO word, stored flat and unpacked per pixel on the way out
	typedef union packed {
		logic [(`VTB_PPC * 3 * `VTB_BPC)-1:0] raw; // Write view
		vtb_pix_t [`VTB_PPC-1:0] pix; // Pixel 0 in the low bits
	} vtb_word_u;

	// Pixel stream in
	typedef struct packed {
		logic sof; // Start of frame
		logic eol; // End of line
		logic vld; // Word valid
		vtb_word_u dat;
	} vtb_axis_t;

	// Video timing
	typedef struct packed {
		logic vs;
		logic hs;
		logic de;
	} vtb_sync_t;

	// Video out
	typedef struct packed {
		logic [(`VTB_PPC * `VTB_BPC)-1:0] r;
		logic [(`VTB_PPC * `VTB_BPC)-1:0] g;
		logic [(`VTB_PPC * `VTB_BPC)-1:0] b;
		logic vs;
		logic hs;
		logic de;
	} vtb_rgb_t;

	// Lock and fill statistics
	typedef struct packed {
		logic lock;
		logic [`VTB_FIFO_ADR:0] max_wrds; // Highest fill at a line start
		logic [`VTB_FIFO_ADR:0] min_wrds; // Lowest fill at a line start
	} vtb_sta_t;

	// FIFO status
	typedef struct packed {
		logic [`VTB_FIFO_ADR:0] wrds; // Used words
		logic ep; // Empty
		logic fl; // Full
	} vtb_fifo_st_t;

	// Lock sequence
	typedef enum logic [2:0] {
		sm_idle,
		sm_sof,
		sm_ep,
		sm_mid,
		sm_vs,
		sm_lock
	} vtb_lock_sm_e;

endpackage

/* vtb_fifo/vtb_fifo_ram.sv */
// Writes into a full buffer and writes during a flush are dropped and an empty read holds the last word
`timescale 1ns/1ps
`include "vtb_settings.svh"

module vtb_fifo_ram
(
	input logic VID_CLK_IN, // Clock
	input logic LNK_CLK_IN, // Reset
	input logic flush, // Clear pointers and count
	input logic wr,
	input vtb_pkg::vtb_word_u din,
	input logic rd,
	output vtb_pkg::vtb_word_u dout, // Registered read data
	output logic dv, // One clock after rd
	output vtb_pkg::vtb_fifo_st_t st
);

	localparam logic [`VTB_FIFO_ADR:0] DEPTH = (`VTB_FIFO_ADR + 1)'(`VTB_FIFO_WRDS);

	// Storage, block RAM style
	vtb_pkg::vtb_word_u mem [0:`VTB_FIFO_WRDS-1];

	logic [`VTB_FIFO_ADR-1:0] wp; // Write pointer
	logic [`VTB_FIFO_ADR-1:0] rp; // Read pointer
	logic [`VTB_FIFO_ADR:0] cnt; // Used words
	logic do_wr;
	logic do_rd;

	// Flags come straight from the count
	assign st.wrds = cnt;
	assign st.ep = (cnt == '0);
	assign st.fl = (cnt == DEPTH);

	assign do_wr = wr && !st.fl && !flush; // No room, word lost
	assign do_rd = rd && !st.ep && !flush; // Underflow reads nothing

	// Pointers and count
	always_ff @(posedge VID_CLK_IN or posedge LNK_CLK_IN)
	begin
		if (LNK_CLK_IN)
		begin
			wp <= '0;
			rp <= '0;
			cnt <= '0;
		end
		else if (flush)
		begin
			wp <= '0;
			rp <= '0;
			cnt <= '0;
		end
		else
		begin
			if (do_wr)
				wp <= wp + 1'b1; // Wraps at depth
			if (do_rd)
				rp <= rp + 1'b1;
			case ({do_wr, do_rd})
				2'b10 : cnt <= cnt + 1'b1;
				2'b01 : cnt <= cnt - 1'b1;
				default : cnt <= cnt; // Both or neither
			endcase
		end
	end

	// Write port
	always_ff @(posedge VID_CLK_IN)
	begin
		if (do_wr)
			mem[wp] <= din;
	end

	// Read port
	always_ff @(posedge VID_CLK_IN)
	begin
		if (do_rd)
			dout <= mem[rp]; // Holds on underflow
	end

	// Data valid follows every read request
	always_ff @(posedge VID_CLK_IN or posedge LNK_CLK_IN)
	begin
		if (LNK_CLK_IN)
			dv <= 1'b0;
		else
			dv <= rd;
	end

	// Count stays within the buffer over any write and read mix
	a_wrds_max : assert property (@(posedge VID_CLK_IN) disable iff (LNK_CLK_IN)
		st.wrds <= DEPTH);

	// Empty and full exclusive
	a_ep_fl : assert property (@(posedge VID_CLK_IN) disable iff (LNK_CLK_IN)
		!(st.ep && st.fl));

endmodule

/* vtb_fifo/vtb_fifo_lock.sv */
// Lock needs a flush, a fill to the midpoint and a new vsync in that order and is lost on any bad read
`timescale 1ns/1ps
`include "vtb_settings.svh"

module vtb_fifo_lock
(
	input logic VID_CLK_IN, // Clock
	input logic LNK_CLK_IN, // Reset
	input logic run,
	input logic sof, // Stream start of frame
	input logic de, // Raw video data enable
	input logic vs_dly, // Vsync after one stage
	input vtb_pkg::vtb_fifo_st_t st,
	output logic rd, // FIFO read
	output logic flush, // FIFO clear
	output logic en, // Output enable
	output logic tg_sync, // Timing generator sync
	output vtb_pkg::vtb_sta_t sta
);

	localparam logic [`VTB_FIFO_ADR:0] MID = (`VTB_FIFO_ADR + 1)'(`VTB_FIFO_MID);

	vtb_pkg::vtb_lock_sm_e sm_cur;
	vtb_pkg::vtb_lock_sm_e sm_nxt;
	vtb_pkg::vtb_lock_sm_e sm_sel; // State as decoded this clock
	logic run_q;
	logic sof_q;
	logic de_q;
	logic de_qq;
	logic vs_q;
	logic de_re; // Line start
	logic vs_re; // Frame start on the video side
	logic mid; // Fill at or above midpoint
	logic loss; // Read with FIFO empty or full
	logic rd_en;
	logic rd_en_set;
	logic rd_en_clr;
	logic en_set;
	logic en_clr;
	logic tg_sync_set;
	logic lock;
	logic [`VTB_FIFO_ADR:0] max_wrds;
	logic [`VTB_FIFO_ADR:0] min_wrds;

	// Input registers
	always_ff @(posedge VID_CLK_IN or posedge LNK_CLK_IN)
	begin
		if (LNK_CLK_IN)
		begin
			run_q <= 1'b0;
			sof_q <= 1'b0;
			de_q <= 1'b0;
			de_qq <= 1'b0;
			vs_q <= 1'b0;
		end
		else
		begin
			run_q <= run;
			sof_q <= sof;
			de_q <= de; // First clock of the data path
			de_qq <= de_q;
			vs_q <= vs_dly;
		end
	end

	assign flush = sof && !sof_q; // Rising edge of sof
	assign de_re = de_q && !de_qq;
	assign vs_re = vs_dly && !vs_q;
	assign mid = (st.wrds >= MID);
	assign rd = rd_en && de_q;
	assign loss = rd && (st.ep || st.fl);

	// A start of frame overrides the current state in the same clock
	assign sm_sel = flush ? vtb_pkg::sm_sof : sm_cur;

	always_ff @(posedge VID_CLK_IN or posedge LNK_CLK_IN)
	begin
		if (LNK_CLK_IN)
			sm_cur <= vtb_pkg::sm_idle;
		else if (!run_q)
			sm_cur <= vtb_pkg::sm_idle;
		else
			sm_cur <= sm_nxt;
	end

	// Next state and strobes
	always_comb
	begin
		sm_nxt = sm_sel;
		rd_en_set = 1'b0;
		rd_en_clr = 1'b0;
		en_set = 1'b0;
		en_clr = 1'b0;
		tg_sync_set = 1'b0;
		case (sm_sel)
			vtb_pkg::sm_idle :
				sm_nxt = vtb_pkg::sm_idle; // Wait for sof
			vtb_pkg::sm_sof :
			begin
				if (lock)
					sm_nxt = vtb_pkg::sm_lock; // Keep streaming
				else
				begin
					rd_en_clr = 1'b1;
					en_clr = 1'b1;
					sm_nxt = vtb_pkg::sm_ep;
				end
			end
			vtb_pkg::sm_ep :
			begin
				if (st.ep)
					sm_nxt = vtb_pkg::sm_mid; // Flush done
			end
			vtb_pkg::sm_mid :
			begin
				if (mid)
				begin
					tg_sync_set = 1'b1;
					rd_en_set = 1'b1; // Reads start, output still gated
					sm_nxt = vtb_pkg::sm_vs;
				end
			end
			vtb_pkg::sm_vs :
			begin
				if (vs_re)
				begin
					en_set = 1'b1;
					sm_nxt = vtb_pkg::sm_lock;
				end
			end
			vtb_pkg::sm_lock :
			begin
				if (!lock)
					sm_nxt = vtb_pkg::sm_idle;
			end
			default :
				sm_nxt = vtb_pkg::sm_idle;
		endcase
	end

	// Read enable, output enable, lock and sync pulse
	always_ff @(posedge VID_CLK_IN or posedge LNK_CLK_IN)
	begin
		if (LNK_CLK_IN)
		begin
			rd_en <= 1'b0;
			en <= 1'b0;
			lock <= 1'b0;
			tg_sync <= 1'b0;
		end
		else
		begin
			tg_sync <= tg_sync_set; // Single clock
			if (!run_q)
			begin
				rd_en <= 1'b0;
				en <= 1'b0;
				lock <= 1'b0;
			end
			else
			begin
				if (rd_en_clr)
					rd_en <= 1'b0;
				else if (rd_en_set)
					rd_en <= 1'b1;
				if (en_set)
					en <= 1'b1;
				else if (en_clr || loss)
					en <= 1'b0; // Blank video on loss
				if (en_set)
					lock <= 1'b1;
				else if (loss)
					lock <= 1'b0;
			end
		end
	end

	// Fill statistics sampled at line starts
	always_ff @(posedge VID_CLK_IN or posedge LNK_CLK_IN)
	begin
		if (LNK_CLK_IN)
		begin
			max_wrds <= MID;
			min_wrds <= MID;
		end
		else if (!lock)
		begin
			max_wrds <= MID; // Parked while unlocked
			min_wrds <= MID;
		end
		else if (de_re)
		begin
			if (st.wrds > max_wrds)
				max_wrds <= st.wrds;
			if (st.wrds < min_wrds)
				min_wrds <= st.wrds;
		end
	end

	assign sta.lock = lock;
	assign sta.max_wrds = max_wrds;
	assign sta.min_wrds = min_wrds;

	// Sync pulse is one clock only
	a_tg_once : assert property (@(posedge VID_CLK_IN) disable iff (LNK_CLK_IN)
		tg_sync |=> !tg_sync);

	// Lock only comes up together with the output enable
	a_lock_rise : assert property (@(posedge VID_CLK_IN) disable iff (LNK_CLK_IN)
		$rose(lock) |-> $past(en_set));

endmodule

/* vtb_fifo/vtb_fifo_out.sv */
// Output lags the input data enable by three clocks and the syncs are delayed by the same amount
`timescale 1ns/1ps
`include "vtb_settings.svh"

module vtb_fifo_out
(
	input logic VID_CLK_IN, // Clock
	input logic LNK_CLK_IN, // Reset
	input vtb_pkg::vtb_sync_t sync, // Raw video timing
	input logic en, // Output enable
	input vtb_pkg::vtb_word_u dout, // FIFO read data
	input logic dv, // FIFO data valid
	output logic vs_dly, // First vsync stage
	output vtb_pkg::vtb_rgb_t vid
);

	logic [2:0] vs_sr; // Vsync delay line
	logic [2:0] hs_sr; // Hsync delay line
	logic dv_q;
	vtb_pkg::vtb_word_u dat_q;

	// Sync delay and data valid
	always_ff @(posedge VID_CLK_IN or posedge LNK_CLK_IN)
	begin
		if (LNK_CLK_IN)
		begin
			vs_sr <= '0;
			hs_sr <= '0;
			dv_q <= 1'b0;
		end
		else
		begin
			vs_sr <= {vs_sr[1:0], sync.vs};
			hs_sr <= {hs_sr[1:0], sync.hs};
			dv_q <= dv; // Third clock of the data path
		end
	end

	// Pixel word
	always_ff @(posedge VID_CLK_IN)
	begin
		dat_q <= dout;
	end

	assign vs_dly = vs_sr[0];

	// Unpack pixels and gate timing
	always_comb
	begin
		for (int i = 0; i < `VTB_PPC; i++)
		begin
			vid.r[(i * `VTB_BPC) +: `VTB_BPC] = dat_q.pix[i].r;
			vid.g[(i * `VTB_BPC) +: `VTB_BPC] = dat_q.pix[i].g;
			vid.b[(i * `VTB_BPC) +: `VTB_BPC] = dat_q.pix[i].b;
		end
		vid.vs = en ? vs_sr[2] : 1'b0;
		vid.hs = en ? hs_sr[2] : 1'b0;
		vid.de = en ? dv_q : 1'b0;
	end

	// Pixel out only where the timing asked for one three clocks back
	a_de_align : assert property (@(posedge VID_CLK_IN) disable iff (LNK_CLK_IN)
		dv_q |-> $past(sync.de, 3));

endmodule

/* verilog/vtb_fifo_top.sv */
// Single clock only and the stream has no ready so the source must keep pace with the video timing
`timescale 1ns/1ps

module vtb_fifo_top
(
	input logic VID_CLK_IN, // Clock
	input logic LNK_CLK_IN, // Reset
	input logic run,
	input vtb_pkg::vtb_axis_t axis, // Pixel stream
	input vtb_pkg::vtb_sync_t vid_in, // Video timing
	output vtb_pkg::vtb_rgb_t vid_out,
	output logic tg_sync,
	output vtb_pkg::vtb_sta_t sta
);

	vtb_pkg::vtb_fifo_st_t fifo_st;
	vtb_pkg::vtb_word_u rd_dat;
	logic flush;
	logic rd;
	logic rd_dv;
	logic en;
	logic vs_dly;

	// Buffer, written on every valid word
	vtb_fifo_ram u_ram
	(
		.VID_CLK_IN (VID_CLK_IN),
		.LNK_CLK_IN (LNK_CLK_IN),
		.flush (flush),
		.wr (axis.vld),
		.din (axis.dat),
		.rd (rd),
		.dout (rd_dat),
		.dv (rd_dv),
		.st (fifo_st)
	);

	// Lock control and statistics
	vtb_fifo_lock u_lock
	(
		.VID_CLK_IN (VID_CLK_IN),
		.LNK_CLK_IN (LNK_CLK_IN),
		.run (run),
		.sof (axis.sof),
		.de (vid_in.de),
		.vs_dly (vs_dly),
		.st (fifo_st),
		.rd (rd),
		.flush (flush),
		.en (en),
		.tg_sync (tg_sync),
		.sta (sta)
	);

	// Video output stage
	vtb_fifo_out u_out
	(
		.VID_CLK_IN (VID_CLK_IN),
		.LNK_CLK_IN (LNK_CLK_IN),
		.sync (vid_in),
		.en (en),
		.dout (rd_dat),
		.dv (rd_dv),
		.vs_dly (vs_dly),
		.vid (vid_out)
	);

endmodule

/* verif/vtb_clk_gen.sv */
// Free running 20 ns clock with an active high reset held for the first 5 rising edges
`timescale 1ns/1ps

module vtb_clk_gen
(
	output logic clk,
	output logic rst
);

	// 50 MHz
	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		rst = 1'b1; // Asserted from time zero
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* verif/vtb_fifo_tb.sv */
// Expects the pattern file under verif and its own timing source which starts each frame on tg_sync
`timescale 1ns/1ps
`include "vtb_settings.svh"

module vtb_fifo_tb;

	localparam int WW = `VTB_PPC * 3 * `VTB_BPC; // FIFO word width
	localparam int BW = `VTB_PPC * `VTB_BPC; // Component bus width
	localparam int MID = `VTB_FIFO_MID;
	localparam int DEPTH = `VTB_FIFO_WRDS;

	logic clk;
	logic rst;
	logic run;
	vtb_pkg::vtb_axis_t axis;
	vtb_pkg::vtb_sync_t vid_in;
	vtb_pkg::vtb_rgb_t vid_out;
	logic tg_sync;
	vtb_pkg::vtb_sta_t sta;

	// Pattern table
	int tid[$];
	int act[$];
	int lns[$];
	int blk[$];
	logic [WW-1:0] seed[$];
	int stp[$];
	int lk[$];

	// Reference model
	logic [WW-1:0] q[$]; // Words written since last sof
	logic [WW-1:0] p1_w; // Popped one clock back
	logic [WW-1:0] p2_w; // Popped two clocks back
	logic p1_v;
	logic p2_v;
	logic lock_exp;
	logic rd_en_exp;
	logic tg_exp;
	logic mid_wait;
	logic vs_wait;
	logic tg_seen; // Starts the timing source
	logic chk_on;
	logic [3:0] vs_h; // Bit 0 is this clock
	logic [3:0] hs_h;
	logic [2:0] de_h;
	logic [1:0] run_h;
	logic [1:0] sof_h;
	int exp_max;
	int exp_min;
	int errs;
	int cyc;
	int limit;

	vtb_clk_gen u_clk (.clk(clk), .rst(rst));

	vtb_fifo_top dut
	(
		.VID_CLK_IN (clk),
		.LNK_CLK_IN (rst),
		.run (run),
		.axis (axis),
		.vid_in (vid_in),
		.vid_out (vid_out),
		.tg_sync (tg_sync),
		.sta (sta)
	);

	task automatic report_error(input string msg);
		$display("** Error at %0t: %s", $time, msg);
		errs++;
	endtask

	// Component bus from a word where sel 0 is g, 1 is r and 2 is b
	function automatic logic [BW-1:0] comp_bus(input logic [WW-1:0] w, input int sel);
		logic [BW-1:0] bus;
		bus = '0;
		for (int p = 0; p < `VTB_PPC; p++)
			bus[p*`VTB_BPC +: `VTB_BPC] = w[p*3*`VTB_BPC + sel*`VTB_BPC +: `VTB_BPC];
		return bus;
	endfunction

	// Run length guard
	always @(negedge clk)
	begin
		cyc++;
		if (cyc > limit)
		begin
			$display("Timeout: no result after %0d clocks", cyc);
			$display("TB FAILED");
			$finish;
		end
	end

	// Checks first and then one model step
	always @(negedge clk)
	begin
		int cnt0;
		logic flush_c;
		logic rd_c;
		logic lock_nx;
		logic rd_en_nx;
		logic tg_nx;
		logic np_v;
		logic [WW-1:0] np_w;
		vs_h = {vs_h[2:0], vid_in.vs};
		hs_h = {hs_h[2:0], vid_in.hs};
		de_h = {de_h[1:0], vid_in.de};
		run_h = {run_h[0], run};
		sof_h = {sof_h[0], axis.sof};
		if (chk_on)
		begin
			if (sta.lock !== lock_exp)
				report_error($sformatf("lock %b, expected %b", sta.lock, lock_exp));
			if (tg_sync !== tg_exp)
				report_error($sformatf("tg_sync %b, expected %b", tg_sync, tg_exp));
			if (vid_out.de !== (p2_v && lock_exp))
				report_error($sformatf("de out %b, expected %b", vid_out.de, p2_v && lock_exp));
			if (lock_exp)
			begin
				if (vid_out.vs !== vs_h[3] || vid_out.hs !== hs_h[3])
					report_error("vs/hs out not input delayed by 3");
			end
			else if (vid_out.vs !== 1'b0 || vid_out.hs !== 1'b0)
				report_error("vs/hs out while unlocked");
			if (vid_out.de && p2_v)
			begin
				if (vid_out.r !== comp_bus(p2_w, 1) || vid_out.g !== comp_bus(p2_w, 0)
					|| vid_out.b !== comp_bus(p2_w, 2))
					report_error($sformatf("pixel mismatch, word %h", p2_w));
			end
			if (int'(sta.max_wrds) != exp_max || int'(sta.min_wrds) != exp_min)
				report_error($sformatf("stats %0d/%0d, expected %0d/%0d",
					sta.max_wrds, sta.min_wrds, exp_max, exp_min));
		end
		if (tg_sync)
			tg_seen = 1'b1; // Timing source may start
		if (!rst)
		begin
			cnt0 = q.size(); // Fill seen by the DUT this clock
			flush_c = sof_h[0] && !sof_h[1];
			rd_c = rd_en_exp && de_h[1]; // Read uses registered de
			lock_nx = lock_exp;
			rd_en_nx = rd_en_exp;
			tg_nx = 1'b0;
			np_v = 1'b0;
			np_w = '0;
			if (!lock_exp)
			begin
				exp_max = MID; // Parked
				exp_min = MID;
			end
			else if (de_h[1] && !de_h[2])
			begin
				if (cnt0 > exp_max)
					exp_max = cnt0;
				if (cnt0 < exp_min)
					exp_min = cnt0;
			end
			if (flush_c)
			begin
				q.delete(); // Write in this clock is dropped too
				rd_en_nx = 1'b0;
				mid_wait = 1'b1;
				vs_wait = 1'b0;
			end
			else
			begin
				if (rd_c && cnt0 == 0)
					lock_nx = 1'b0; // Underflow
				if (rd_c && cnt0 > 0)
				begin
					np_w = q.pop_front();
					np_v = 1'b1;
				end
				if (axis.vld && cnt0 < DEPTH)
					q.push_back(axis.dat.raw);
				if (vs_wait && vs_h[1] && !vs_h[2])
				begin
					lock_nx = 1'b1; // Rising delayed vsync
					vs_wait = 1'b0;
				end
				if (mid_wait && cnt0 >= MID)
				begin
					tg_nx = 1'b1;
					rd_en_nx = 1'b1;
					mid_wait = 1'b0;
					vs_wait = 1'b1;
				end
			end
			if (!run_h[1])
			begin
				lock_nx = 1'b0; // run_q low clears all
				rd_en_nx = 1'b0;
				mid_wait = 1'b0;
				vs_wait = 1'b0;
			end
			lock_exp = lock_nx;
			rd_en_exp = rd_en_nx;
			tg_exp = tg_nx;
			p2_v = p1_v;
			p2_w = p1_w;
			p1_v = np_v;
			p1_w = np_w;
		end
	end

	task automatic load_patterns(output logic ok);
		int fd;
		int n;
		int a[7];
		logic [WW-1:0] s;
		string line;
		ok = 1'b0;
		fd = $fopen("verif/vtb_fifo_patterns.txt", "r");
		if (fd != 0)
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#")
				begin
					n = $sscanf(line, "%d %d %d %d %h %d %d",
						a[0], a[1], a[2], a[3], s, a[5], a[6]);
					if (n == 7)
					begin
						tid.push_back(a[0]);
						act.push_back(a[1]);
						lns.push_back(a[2]);
						blk.push_back(a[3]);
						seed.push_back(s);
						stp.push_back(a[5]);
						lk.push_back(a[6]);
					end
				end
			end
			$fclose(fd);
			ok = (tid.size() > 0);
		end
	endtask

	// Stream source with scattered gaps
	task automatic write_words(input int nwr, input logic [WW-1:0] base);
		int i;
		i = 0;
		while (i < nwr)
		begin
			@(posedge clk);
			if ($urandom_range(3) == 0)
				axis.vld <= 1'b0;
			else
			begin
				axis.vld <= 1'b1;
				axis.dat.raw <= base + WW'(i); // Seed plus index
				i++;
			end
		end
		@(posedge clk);
		axis.vld <= 1'b0;
	endtask

	// Timing source with two vsync lines then active lines
	task automatic drive_frame(input int t);
		while (!tg_seen)
			@(posedge clk);
		for (int l = 0; l < lns[t] + 2; l++)
		begin
			for (int x = 0; x < act[t] + blk[t]; x++)
			begin
				@(posedge clk);
				vid_in.vs <= (l < 2);
				vid_in.hs <= (x < 4);
				vid_in.de <= (l >= 2 && x >= blk[t]);
			end
		end
		@(posedge clk);
		vid_in <= '0;
	endtask

	task automatic run_test(input int t);
		int e0;
		int nwr;
		e0 = errs;
		@(posedge clk);
		if (lock_exp)
		begin
			run <= 1'b0; // Leave lock before the next frame
			repeat (3) @(posedge clk);
		end
		run <= 1'b1;
		repeat (3) @(posedge clk);
		tg_seen = 1'b0;
		axis.sof <= 1'b1;
		axis.vld <= 1'b0;
		@(posedge clk);
		axis.sof <= 1'b0;
		nwr = stp[t] ? MID + 2 * act[t] : MID + act[t] * lns[t];
		fork
			write_words(nwr, seed[t]);
			drive_frame(t);
		join
		repeat (6) @(posedge clk);
		@(negedge clk);
		if (int'(sta.lock) != lk[t])
			report_error($sformatf("lock %b at end, expected %0d", sta.lock, lk[t]));
		if (lk[t] != 0 && (int'(sta.max_wrds) < MID || int'(sta.min_wrds) > MID))
			report_error("stats outside midpoint bounds");
		$display("test %0d act %0d lines %0d stop %0d: %0d errors",
			tid[t], act[t], lns[t], stp[t], errs - e0);
	endtask

	initial
	begin
		logic ok;
		run = 1'b0;
		axis = '0;
		vid_in = '0;
		q.delete();
		{p1_v, p2_v, lock_exp, rd_en_exp, tg_exp} = '0;
		{mid_wait, vs_wait, tg_seen, chk_on} = '0;
		p1_w = '0;
		p2_w = '0;
		{vs_h, hs_h, de_h, run_h, sof_h} = '0;
		exp_max = MID;
		exp_min = MID;
		errs = 0;
		cyc = 0;
		limit = 1000000; // Until the table is read
		void'($urandom(32'h7020));
		load_patterns(ok);
		if (!ok)
		begin
			$display("Pattern file missing or empty");
			$display("TB FAILED");
			$finish;
		end
		else
		begin
			limit = 5000;
			foreach (tid[t])
				limit += (act[t] + blk[t]) * (lns[t] + 2) * 3;
			while (rst !== 1'b0)
				@(posedge clk);
			chk_on = 1'b1;
			repeat (4) @(posedge clk); // Idle with run low
			@(negedge clk);
			if (sta.lock || tg_sync || vid_out.de || vid_out.vs || vid_out.hs)
				report_error("outputs not idle after reset");
			if (int'(sta.max_wrds) != MID || int'(sta.min_wrds) != MID)
				report_error("stats not at midpoint after reset");
			$display("test 1 reset and idle: %0d errors", errs);
			foreach (tid[t])
				run_test(t);
			$display("%0d tests done, %0d errors", tid.size() + 1, errs);
			if (errs == 0)
				$display("TB PASSED");
			else
				$display("TB FAILED");
			$finish;
		end
	end

endmodule

/* verif/vtb_fifo_patterns.txt */
# One test per line: id, active words per line, active lines, blanking clocks,
# pixel seed (hex word), stop writes early (1 = underflow expected), expected lock at end
#
# Plain frame, lock held
2 16 20 16 00000a1b2000 0 1
#
# Writes stop after midpoint plus two lines, lock lost
3 32 24 16 00000c3d4000 1 0
#
# Relock straight after the loss
4 16 20 16 00000e5f6000 0 1
#
# Short blanking, higher read rate
5 24 12 8 000011220000 0 1
#
# Narrow lines, long blanking
6 8 40 24 000033440000 0 1
#
# Second underflow from a locked start
7 32 24 16 000055660000 1 0
#
# Relock again with fresh pixels
8 12 30 12 000077880000 0 1

/* vtb_fifo.f */
+incdir+common
common/vtb_pkg.sv
vtb_fifo/vtb_fifo_ram.sv
vtb_fifo/vtb_fifo_lock.sv
vtb_fifo/vtb_fifo_out.sv
verilog/vtb_fifo_top.sv
verif/vtb_clk_gen.sv
verif/vtb_fifo_tb.sv

/* Makefile */
TOP = vtb_fifo_tb

all: run

compile:
	verilator --binary --timing --assert -f vtb_fifo.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean
